// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_stage_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
design/mem_stage_pkg.sv
design/mem_bus_if.sv
design/lsu_align.sv
design/lsu_ctrl.sv
design/data_ram.sv
design/mem_stage_top.sv
dv/tb_clkgen.sv
dv/mem_stage_tb.sv

// File: design/data_ram.sv
// Byte-masked data RAM

`timescale 1ns/1ps

module data_ram import mem_stage_pkg::*; #(
	parameter int DEPTH_WORDS = 256,
	parameter int RAM_AW      = 8
) (
	input  logic     clk,
	input  logic     rst_n,
	mem_bus_if.slave bus
);

	word_t mem [DEPTH_WORDS];
	logic  ready_q;
	logic  take;

	assign bus.req_ready = ready_q;
	assign take          = bus.req_valid && ready_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q      <= 1'b0;
			bus.rd_valid <= 1'b0;
			for (int w = 0; w < DEPTH_WORDS; w++)
				mem[w] <= '0;
		end else begin
			ready_q      <= 1'b1;
			bus.rd_valid <= take && !bus.req_we;
			// only the enabled lanes change
			if (take && bus.req_we) begin
				for (int b = 0; b < 4; b++) begin
					if (bus.req_wmask[b])
						mem[bus.req_addr][8*b +: 8] <= bus.req_wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && !bus.req_we)
			bus.rd_data <= mem[bus.req_addr];
	end

endmodule

// File: design/lsu_align.sv
// Load/store lane aligner

`timescale 1ns/1ps

module lsu_align import mem_stage_pkg::*; (
	input  logic       store,
	input  funct3_t    funct3,
	input  addr_t      addr,
	input  word_t      wdata,
	input  word_t      rd_data,
	output word_t      wword,
	output byte_mask_t wmask,
	output addr_t      word_addr,
	output logic       misaligned,
	output word_t      ld_result
);

	logic [1:0] lane;
	logic [4:0] lane_shift;
	logic       illegal;
	logic       bad_align;
	word_t      wtrunc;
	byte_mask_t base_mask;
	word_t      ld_shifted;

	assign lane       = addr[1:0];
	assign lane_shift = {lane, 3'b000};

	// word index into the RAM, the low address bits pick the lane
	assign word_addr = {2'b00, addr[31:2]};

	////////////////////////////////////////////////////////////
	// size and alignment checks
	////////////////////////////////////////////////////////////

	// size code 3 is never legal, stores also reject the unsigned codes
	assign illegal = (funct3[1:0] == 2'b11) || (funct3[2] && (store || funct3[1]));

	always_comb begin
		case (funct3[1:0])
			2'b01:   bad_align = lane[0];
			2'b10:   bad_align = (lane != 2'b00);
			default: bad_align = 1'b0;
		endcase
	end

	assign misaligned = illegal || bad_align;

	////////////////////////////////////////////////////////////
	// store path
	////////////////////////////////////////////////////////////

	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				wtrunc    = {24'h0, wdata[7:0]};
				base_mask = 4'b0001;
			end
			2'b01: begin
				wtrunc    = {16'h0, wdata[15:0]};
				base_mask = 4'b0011;
			end
			2'b10: begin
				wtrunc    = wdata;
				base_mask = 4'b1111;
			end
			default: begin
				wtrunc    = '0;
				base_mask = 4'b0000;
			end
		endcase
	end

	assign wword = wtrunc << lane_shift;

	// a rejected access writes no lane at all
	assign wmask = (store && !misaligned) ? byte_mask_t'(base_mask << lane) : 4'b0000;

	////////////////////////////////////////////////////////////
	// load path
	////////////////////////////////////////////////////////////

	assign ld_shifted = rd_data >> lane_shift;

	always_comb begin
		case (funct3)
			F3_LB:   ld_result = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
			F3_LH:   ld_result = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
			F3_LW:   ld_result = ld_shifted;
			F3_LBU:  ld_result = {24'h0, ld_shifted[7:0]};
			F3_LHU:  ld_result = {16'h0, ld_shifted[15:0]};
			default: ld_result = '0;
		endcase
	end

endmodule

// File: design/lsu_ctrl.sv
// Load/store controller

`timescale 1ns/1ps

module lsu_ctrl import mem_stage_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  logic       op_valid,
	output logic       op_ready,
	input  logic       op_store,
	input  funct3_t    op_funct3,
	input  addr_t      op_addr,
	input  word_t      op_wdata,

	output logic       rsp_valid,
	input  logic       rsp_ready,
	output word_t      rsp_data,
	output logic       rsp_err,

	mem_bus_if.master  bus,

	output logic       al_store,
	output funct3_t    al_funct3,
	output addr_t      al_addr,
	output word_t      al_wdata,
	output word_t      al_rd_data,
	input  word_t      al_wword,
	input  byte_mask_t al_wmask,
	input  addr_t      al_word_addr,
	input  logic       al_misaligned,
	input  word_t      al_ld_result
);

	ctrl_state_t state;

	logic    store_q;
	funct3_t funct3_q;
	addr_t   addr_q;
	word_t   wdata_q;
	word_t   rsp_data_q;
	logic    rsp_err_q;

	logic    accept;

	assign accept = op_valid && op_ready;

	// the aligner always works on the operation held here
	assign al_store   = store_q;
	assign al_funct3  = funct3_q;
	assign al_addr    = addr_q;
	assign al_wdata   = wdata_q;
	assign al_rd_data = bus.rd_data;

	assign op_ready  = (state == IDLE);
	assign rsp_valid = (state == RESPOND);
	assign rsp_data  = rsp_data_q;
	assign rsp_err   = rsp_err_q;

	////////////////////////////////////////////////////////////
	// memory bus request
	////////////////////////////////////////////////////////////

	assign bus.req_valid = (state == ISSUE) && !al_misaligned;
	assign bus.req_we    = store_q;
	assign bus.req_addr  = al_word_addr[$bits(bus.req_addr)-1:0];
	assign bus.req_wdata = al_wword;
	assign bus.req_wmask = al_wmask;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (accept)
						state <= ISSUE;
				end
				ISSUE: begin
					if (al_misaligned)
						state <= RESPOND;
					else if (bus.req_ready)
						state <= store_q ? RESPOND : WAIT_RD;
				end
				WAIT_RD: begin
					if (bus.rd_valid)
						state <= RESPOND;
				end
				RESPOND: begin
					if (rsp_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// operation and response payload
	always_ff @(posedge clk) begin
		if (accept) begin
			store_q  <= op_store;
			funct3_q <= op_funct3;
			addr_q   <= op_addr;
			wdata_q  <= op_wdata;
		end
		if (state == ISSUE && (al_misaligned || (bus.req_ready && store_q))) begin
			rsp_data_q <= '0;
			rsp_err_q  <= al_misaligned;
		end
		if (state == WAIT_RD && bus.rd_valid) begin
			rsp_data_q <= al_ld_result;
			rsp_err_q  <= 1'b0;
		end
	end

endmodule

// File: design/mem_bus_if.sv
// Data RAM bus

`timescale 1ns/1ps

interface mem_bus_if import mem_stage_pkg::*; #(
	parameter int RAM_AW = 8
) ();

	logic              req_valid;
	logic              req_ready;
	logic              req_we;
	logic [RAM_AW-1:0] req_addr;
	word_t             req_wdata;
	byte_mask_t        req_wmask;

	// read data comes back one edge after the request is taken
	logic  rd_valid;
	word_t rd_data;

	modport master (
		output req_valid, req_we, req_addr, req_wdata, req_wmask,
		input  req_ready, rd_valid, rd_data
	);

	modport slave (
		input  req_valid, req_we, req_addr, req_wdata, req_wmask,
		output req_ready, rd_valid, rd_data
	);

endinterface

// File: design/mem_stage_pkg.sv
// Memory stage shared types

package mem_stage_pkg;

	////////////////////////////////////////////////////////////
	// data and address types
	////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// bit i enables byte lane i of a word
	typedef logic [3:0] byte_mask_t;

	typedef logic [2:0] funct3_t;

	////////////////////////////////////////////////////////////
	// access size codes
	////////////////////////////////////////////////////////////

	localparam funct3_t F3_LB  = 3'd0;
	localparam funct3_t F3_LH  = 3'd1;
	localparam funct3_t F3_LW  = 3'd2;
	localparam funct3_t F3_LBU = 3'd4;
	localparam funct3_t F3_LHU = 3'd5;

	localparam funct3_t F3_SB = 3'd0;
	localparam funct3_t F3_SH = 3'd1;
	localparam funct3_t F3_SW = 3'd2;

	// states of the load/store controller
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_RD,
		RESPOND
	} ctrl_state_t;

endpackage

// File: design/mem_stage_top.sv
// Memory stage top level

`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; #(
	parameter int DEPTH_WORDS = 256
) (
	input  logic    clk,
	input  logic    rst_n,

	input  logic    op_valid,
	output logic    op_ready,
	input  logic    op_store,
	input  funct3_t op_funct3,
	input  addr_t   op_addr,
	input  word_t   op_wdata,

	output logic    rsp_valid,
	input  logic    rsp_ready,
	output word_t   rsp_data,
	output logic    rsp_err
);

	localparam int RAM_AW = $clog2(DEPTH_WORDS);

	logic       al_store;
	funct3_t    al_funct3;
	addr_t      al_addr;
	word_t      al_wdata;
	word_t      al_rd_data;
	word_t      al_wword;
	byte_mask_t al_wmask;
	addr_t      al_word_addr;
	logic       al_misaligned;
	word_t      al_ld_result;

	mem_bus_if #(.RAM_AW(RAM_AW)) bus ();

	lsu_ctrl ctrl_i (
		.clk,
		.rst_n,
		.op_valid,
		.op_ready,
		.op_store,
		.op_funct3,
		.op_addr,
		.op_wdata,
		.rsp_valid,
		.rsp_ready,
		.rsp_data,
		.rsp_err,
		.bus           (bus.master),
		.al_store,
		.al_funct3,
		.al_addr,
		.al_wdata,
		.al_rd_data,
		.al_wword,
		.al_wmask,
		.al_word_addr,
		.al_misaligned,
		.al_ld_result
	);

	lsu_align align_i (
		.store      (al_store),
		.funct3     (al_funct3),
		.addr       (al_addr),
		.wdata      (al_wdata),
		.rd_data    (al_rd_data),
		.wword      (al_wword),
		.wmask      (al_wmask),
		.word_addr  (al_word_addr),
		.misaligned (al_misaligned),
		.ld_result  (al_ld_result)
	);

	data_ram #(
		.DEPTH_WORDS (DEPTH_WORDS),
		.RAM_AW      (RAM_AW)
	) ram_i (
		.clk,
		.rst_n,
		.bus (bus.slave)
	);

endmodule

// File: dv/mem_stage_tb.sv
// Memory stage testbench

`timescale 1ns/1ps

module mem_stage_tb import mem_stage_pkg::*; ();

	localparam int DEPTH_WORDS  = 256;
	localparam int PERIOD_NS    = 40;
	localparam int RESET_CYCLES = 16;
	localparam int OP_TOTAL     = 400;
	localparam int TIMEOUT_NS   = (OP_TOTAL * 20 + RESET_CYCLES) * PERIOD_NS;

	logic    clk;
	logic    rst_n;
	logic    op_valid;
	logic    op_ready;
	logic    op_store;
	funct3_t op_funct3;
	addr_t   op_addr;
	word_t   op_wdata;
	logic    rsp_valid;
	logic    rsp_ready;
	word_t   rsp_data;
	logic    rsp_err;

	integer      seed;
	integer      bp_seed;
	logic        bp_mode;
	word_t       shadow [DEPTH_WORDS];
	logic [32:0] exp_q [$];
	int          checks;
	int          mismatches;
	int          proto_errors;
	int          setup_errors;
	int          in_flight;
	logic        hold_vld;
	word_t       hold_data;
	logic        hold_err;

	tb_clkgen #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (RESET_CYCLES)
	) clkgen_i (
		.clk,
		.rst_n
	);

	mem_stage_top #(.DEPTH_WORDS(DEPTH_WORDS)) dut_i (.*);

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// returns {err, data} and applies stores to the shadow memory
	function automatic logic [32:0] expected_response(input logic store, input funct3_t f3,
			input addr_t addr, input word_t wdata);
		int    size;
		int    lane;
		int    idx;
		word_t w;
		word_t ld;
		lane = int'(addr[1:0]);
		idx  = int'(addr[31:2]) % DEPTH_WORDS;
		case (f3)
			3'd0, 3'd4: size = 1;
			3'd1, 3'd5: size = 2;
			3'd2:       size = 4;
			default:    size = 0;
		endcase
		if (store && f3[2])
			size = 0;
		if (size == 0 || lane % size != 0)
			return {1'b1, 32'h0};
		if (store) begin
			for (int i = 0; i < size; i++)
				shadow[idx][8*(lane+i) +: 8] = wdata[8*i +: 8];
			return '0;
		end
		w = shadow[idx] >> (8 * lane);
		case (f3)
			3'd0:    ld = {{24{w[7]}}, w[7:0]};
			3'd1:    ld = {{16{w[15]}}, w[15:0]};
			3'd4:    ld = {24'h0, w[7:0]};
			3'd5:    ld = {16'h0, w[15:0]};
			default: ld = w;
		endcase
		return {1'b0, ld};
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// called 1 ns after a rising edge, returns 1 ns after the accepting edge
	task automatic send_op(input logic store, input funct3_t f3, input addr_t addr,
			input word_t wdata);
		op_valid  = 1'b1;
		op_store  = store;
		op_funct3 = f3;
		op_addr   = addr;
		op_wdata  = wdata;
		while (!op_ready) begin
			@(posedge clk);
			#1;
		end
		exp_q.push_back(expected_response(store, f3, addr, wdata));
		@(posedge clk);
		#1;
		op_valid = 1'b0;
	endtask

	task automatic random_op();
		logic [31:0] r;
		logic [31:0] d;
		funct3_t     f3;
		addr_t       addr;
		logic        store;
		r     = $random(seed);
		d     = $random(seed);
		store = r[8];
		f3    = r[2:0];
		addr  = 32'h100 + {27'h0, r[13:9]};
		// seven in eight operations are legal and aligned
		if (r[5:3] != 3'b000) begin
			if (f3[1:0] == 2'b11)
				f3[1:0] = 2'b10;
			if (store || f3[1])
				f3[2] = 1'b0;
			if (f3[1])
				addr[1:0] = 2'b00;
			else if (f3[0])
				addr[0] = 1'b0;
		end
		send_op(store, f3, addr, d);
	endtask

	initial begin
		stretch_ready();
	end

	task automatic stretch_ready();
		int stretch;
		bp_seed   = 9;
		rsp_ready = 1'b1;
		stretch   = 0;
		forever begin
			@(posedge clk);
			#1;
			if (!bp_mode) begin
				rsp_ready = 1'b1;
			end else if (stretch > 0) begin
				stretch--;
			end else begin
				rsp_ready = ~rsp_ready;
				stretch   = $random(bp_seed) & 7;
			end
		end
	endtask

	initial begin
		logic [31:0] rnd;
		seed      = 9;
		bp_mode   = 1'b0;
		op_valid  = 1'b0;
		op_store  = 1'b0;
		op_funct3 = '0;
		op_addr   = '0;
		op_wdata  = '0;
		setup_errors = 0;
		for (int w = 0; w < DEPTH_WORDS; w++)
			shadow[w] = '0;
		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;
		assert (op_ready && !rsp_valid) else begin
			setup_errors++;
			$display("op_ready low or rsp_valid high right after reset");
		end

		// word store then word load
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			send_op(1'b1, F3_SW, 32'h10 + 4 * i, rnd);
			send_op(1'b0, F3_LW, 32'h10 + 4 * i, 32'h0);
		end

		// narrow stores merge into the word
		send_op(1'b1, F3_SW, 32'h40, 32'h0123_4567);
		for (int l = 0; l < 4; l++) begin
			rnd = $random(seed);
			send_op(1'b1, F3_SB, 32'h40 + l, rnd);
			send_op(1'b0, F3_LW, 32'h40, 32'h0);
		end
		send_op(1'b1, F3_SW, 32'h44, 32'h89ab_cdef);
		for (int l = 0; l < 4; l += 2) begin
			rnd = $random(seed);
			send_op(1'b1, F3_SH, 32'h44 + l, rnd);
			send_op(1'b0, F3_LW, 32'h44, 32'h0);
		end

		// each byte lane holds a set and a clear top bit across the two patterns
		for (int p = 0; p < 2; p++) begin
			send_op(1'b1, F3_SW, 32'h50, (p == 0) ? 32'h807f_807f : 32'h7f80_7f80);
			for (int l = 0; l < 4; l++) begin
				send_op(1'b0, F3_LB, 32'h50 + l, 32'h0);
				send_op(1'b0, F3_LBU, 32'h50 + l, 32'h0);
				if (l % 2 == 0) begin
					send_op(1'b0, F3_LH, 32'h50 + l, 32'h0);
					send_op(1'b0, F3_LHU, 32'h50 + l, 32'h0);
				end
			end
		end

		// rejected accesses must leave the word alone
		send_op(1'b1, F3_SW, 32'h60, 32'hcafe_f00d);
		for (int l = 1; l < 4; l++) begin
			send_op(1'b1, F3_SW, 32'h60 + l, 32'hffff_ffff);
			send_op(1'b0, F3_LW, 32'h60 + l, 32'h0);
			if (l % 2 == 1) begin
				send_op(1'b1, F3_SH, 32'h60 + l, 32'hffff_ffff);
				send_op(1'b0, F3_LH, 32'h60 + l, 32'h0);
				send_op(1'b0, F3_LHU, 32'h60 + l, 32'h0);
			end
		end
		for (int f = 3; f < 8; f++)
			send_op(1'b1, funct3_t'(f), 32'h60, 32'hffff_ffff);
		send_op(1'b0, 3'd3, 32'h60, 32'h0);
		send_op(1'b0, 3'd6, 32'h60, 32'h0);
		send_op(1'b0, 3'd7, 32'h60, 32'h0);
		send_op(1'b0, F3_LW, 32'h60, 32'h0);

		bp_mode = 1'b1;
		repeat (30) random_op();
		bp_mode = 1'b0;
		repeat (300) random_op();

		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		assert (op_ready && !rsp_valid) else begin
			setup_errors++;
			$display("the DUT did not return to idle after the last response");
		end
		$display("checks %0d, mismatches %0d, protocol errors %0d, other errors %0d",
			checks, mismatches, proto_errors, setup_errors);
		if (mismatches == 0 && proto_errors == 0 && setup_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// response checking
	////////////////////////////////////////////////////////////

	// outputs are sampled mid-cycle, away from the driving edge
	initial begin
		checks       = 0;
		mismatches   = 0;
		proto_errors = 0;
		in_flight    = 0;
		hold_vld     = 1'b0;
	end

	always @(negedge clk) begin
		logic [32:0] want;
		if (rst_n) begin
			if (hold_vld) begin
				assert (rsp_valid && rsp_data === hold_data && rsp_err === hold_err) else begin
					mismatches++;
					$display("Mismatch at %0t: response changed while rsp_ready was low", $time);
				end
			end
			hold_vld  = rsp_valid && !rsp_ready;
			hold_data = rsp_data;
			hold_err  = rsp_err;
			assert (!(in_flight > 0 && op_ready)) else begin
				proto_errors++;
				$display("op_ready went high at %0t before the response was taken", $time);
			end
			assert (!rsp_valid || exp_q.size() > 0) else begin
				proto_errors++;
				$display("a response came at %0t with no operation outstanding", $time);
			end
			if (op_valid && op_ready)
				in_flight++;
			if (rsp_valid && rsp_ready) begin
				in_flight--;
				if (exp_q.size() > 0) begin
					want = exp_q.pop_front();
					checks++;
					assert (rsp_data === want[31:0] && rsp_err === want[32]) else begin
						mismatches++;
						$display("Mismatch at %0t: data %h err %b, expected data %h err %b",
							$time, rsp_data, rsp_err, want[31:0], want[32]);
					end
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: dv/tb_clkgen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release lands just after an edge so no flop sees it on the edge itself
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule
